//--- verilog.f
+incdir+include
verilog/decodePkg.sv
verilog/instrControl.sv
verilog/aluControl.sv
verilog/regFileBypass.sv
verilog/wbTagPipe.sv
verilog/decode.sv
bench/decodeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module decodeTb -f verilog.f -o decodeSim \
    || { echo "FAIL: build error"; exit 1; }
./obj_dir/decodeSim > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/decodeTb.sv
// Directed testbench for the decode stage: reference decode model, check task and tests
`include "decode_settings.svh"

module decodeTb;

    import decodePkg::*;

    localparam int TIMEOUT = 20;
    localparam logic [`DATA_WIDTH-1:0] NOP_WORD = 16'h0800;
    // ADDI writing r7, held during reset so uncleared tags would show a write
    localparam logic [`DATA_WIDTH-1:0] ADDI_R7_WORD = 16'h47FF;

    logic                   clk;
    logic                   rstN;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] instrNext;
    logic [`DATA_WIDTH-1:0] wbData;
    logic                   nopInsert;
    ctrl_t                  ctrl;
    aluCtrl_t               alu;
    immSet_t                imm;
    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;
    wbTag_t                 stage1;
    wbTag_t                 stage2;
    wbTag_t                 wbTag;
    logic                   valid;
    logic                   branchKill;
    integer                 seed;

    decode u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrNext  (instrNext),
        .wbData     (wbData),
        .nopInsert  (nopInsert),
        .ctrl       (ctrl),
        .alu        (alu),
        .imm        (imm),
        .rsData     (rsData),
        .rtData     (rtData),
        .stage1     (stage1),
        .stage2     (stage2),
        .wbTag      (wbTag),
        .valid      (valid),
        .branchKill (branchKill)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] expVal,
                         input logic [63:0] actVal);
        if (actVal !== expVal) begin
            $display("ERR %s expected %h actual %h", name, expVal, actVal);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    // Reference control word from the decode table
    function automatic ctrl_t modelCtrl(input logic [4:0] op);
        ctrl_t c;
        c = '0;
        c.nHalt = 1'b1;
        case (op)
            5'b01000: begin
                c.bSrc   = 2'b01;
                c.immSrc = 1'b1;
            end
            5'b01011: c.bSrc = 2'b01;
            5'b10001: begin
                c.bSrc    = 2'b01;
                c.memRead = 1'b1;
                c.regSrc  = 2'b01;
            end
            5'b10000: begin
                c.bSrc   = 2'b01;
                c.memWrt = 1'b1;
            end
            5'b11000: begin
                c.bSrc   = 2'b10;
                c.regSrc = 2'b11;
            end
            5'b11011: c = c;
            5'b01100: begin
                c.bSrc       = 2'b10;
                c.branchKind = 4'b0100;
            end
            5'b00100, 5'b00110: begin
                c.bSrc       = 2'b11;
                c.branchKind = 4'b1000;
                c.aluJmp     = 1'b1;
                if (op == 5'b00110) begin
                    c.regSrc = 2'b10;
                end
            end
            5'b00000: c.nHalt = 1'b0;
            default: c.nop = 1'b1;
        endcase
        return c;
    endfunction

    // Operation codes 0 add, 1 and, 2 xor, 3 passB
    function automatic aluCtrl_t modelAlu(input logic [4:0] op, input logic [1:0] funct);
        aluCtrl_t a;
        a = '0;
        if (op == 5'b01011) begin
            a.oper = 4'd1;
            a.invB = 1'b1;
        end else if (op == 5'b11000) begin
            a.oper = 4'd3;
        end else if (op == 5'b11011) begin
            a.oper = (funct == 2'b10) ? 4'd1 : (funct == 2'b11) ? 4'd2 : 4'd0;
            a.invB = (funct == 2'b01);
            a.cin  = (funct == 2'b01);
        end
        return a;
    endfunction

    function automatic logic modelRegWrt(input logic [4:0] op);
        return op inside {5'b01000, 5'b01011, 5'b10001, 5'b11000, 5'b11011, 5'b00110};
    endfunction

    function automatic logic [2:0] modelRd(input logic [15:0] word);
        case (word[15:11])
            5'b11000: return word[10:8];
            5'b11011: return word[4:2];
            5'b00110: return 3'd7;
            default:  return word[7:5];
        endcase
    endfunction

    function automatic immSet_t modelImm(input logic [15:0] word, input logic zext);
        immSet_t m;
        m.sImm8  = {{8{word[7]}}, word[7:0]};
        m.sImm11 = {{5{word[10]}}, word[10:0]};
        m.imm5   = zext ? {11'b0, word[4:0]} : {{11{word[4]}}, word[4:0]};
        m.imm8   = zext ? {8'b0, word[7:0]} : m.sImm8;
        return m;
    endfunction

    // Destination only matters when the instruction writes
    task automatic checkTag(input string name, input logic [15:0] word, input wbTag_t act);
        check(name, 64'(modelRegWrt(word[15:11])), 64'(act.regWrt));
        if (modelRegWrt(word[15:11])) begin
            check(name, 64'(modelRd(word)), 64'(act.rd));
        end
    endtask

    task automatic flushPipe();
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            instr     <= NOP_WORD;
            nopInsert <= 1'b0;
            wbData    <= '0;
        end
    endtask

    task automatic releaseReset();
        int waited;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
        end
        rstN  <= 1'b1;
        instr <= NOP_WORD;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abortRun("timeout: reset never released");
            end
        end while (!rstN);
    endtask

    // Tags are read before any clock edge outside reset
    task automatic testReset();
        check("reset stage1", 64'(0), 64'(stage1));
        check("reset stage2", 64'(0), 64'(stage2));
        check("reset wbTag", 64'(0), 64'(wbTag));
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(posedge clk);
            instr <= {5'b00001, 3'(i), 3'(i), 5'b0};
            @(negedge clk);
            check("reset rsData", 64'(0), 64'(rsData));
            check("reset rtData", 64'(0), 64'(rtData));
        end
    endtask

    task automatic testControl();
        logic [15:0] words[$];
        logic [15:0] word;
        logic [15:0] prevWord;
        logic [4:0]  op;
        words.push_back({5'b00000, 11'($random(seed))});
        words.push_back({5'b00001, 11'($random(seed))});
        words.push_back({5'b00100, 11'($random(seed))});
        words.push_back({5'b00110, 11'($random(seed))});
        words.push_back({5'b01000, 11'($random(seed))});
        words.push_back({5'b01011, 11'($random(seed))});
        words.push_back({5'b01100, 11'($random(seed))});
        words.push_back({5'b10000, 11'($random(seed))});
        words.push_back({5'b10001, 11'($random(seed))});
        words.push_back({5'b11000, 11'($random(seed))});
        for (int f = 0; f < 4; f++) begin
            words.push_back({5'b11011, 9'($random(seed)), 2'(f)});
        end
        // Undefined opcode
        words.push_back({5'b11111, 11'($random(seed))});
        words.push_back(NOP_WORD);
        flushPipe();
        prevWord = NOP_WORD;
        foreach (words[i]) begin
            word = words[i];
            op   = word[15:11];
            @(posedge clk);
            instr <= word;
            @(negedge clk);
            check("ctrl decode", 64'(modelCtrl(op)), 64'(ctrl));
            check("alu decode", 64'(modelAlu(op, word[1:0])), 64'(alu));
            checkTag("dst decode", prevWord, stage1);
            prevWord = word;
        end
    endtask

    task automatic testImmediates();
        logic [15:0] word;
        logic [4:0]  op;
        for (int i = 0; i < 16; i++) begin
            op   = i[0] ? 5'b01011 : 5'b01000;
            word = {op, 11'($random(seed))};
            @(posedge clk);
            instr <= word;
            @(negedge clk);
            check("immediates", 64'(modelImm(word, op == 5'b01011)), 64'(imm));
        end
    endtask

    task automatic testWriteBack();
        logic [2:0]  rd;
        logic [15:0] data;
        wbTag_t      expTag;
        int          edges;
        int          seen1;
        int          seen2;
        int          seen3;
        flushPipe();
        rd     = 3'($random(seed));
        data   = 16'($random(seed));
        expTag = '{regWrt: 1'b1, rd: rd};
        @(posedge clk);
        instr  <= {5'b01000, 3'($random(seed)), rd, 5'($random(seed))};
        wbData <= data;
        edges  = 0;
        seen1  = 0;
        seen2  = 0;
        seen3  = 0;
        // Follow the tag down the pipe while reading the target register
        while (seen3 == 0) begin
            @(posedge clk);
            instr <= {5'b00001, rd, rd, 5'b0};
            edges++;
            @(negedge clk);
            if (seen1 == 0 && stage1 === expTag) seen1 = edges;
            if (seen2 == 0 && stage2 === expTag) seen2 = edges;
            if (wbTag === expTag) seen3 = edges;
            if (edges > TIMEOUT) begin
                abortRun("timeout: write-back tag never reached wbTag");
            end
        end
        check("wb stage1 latency", 64'(1), 64'(seen1));
        check("wb stage2 latency", 64'(2), 64'(seen2));
        check("wb wbTag latency", 64'(3), 64'(seen3));
        check("wb bypass rs", 64'(data), 64'(rsData));
        check("wb bypass rt", 64'(data), 64'(rtData));
        @(posedge clk);
        wbData <= ~data;
        @(negedge clk);
        check("wb tag retired", 64'(0), 64'(wbTag.regWrt));
        check("wb stored rs", 64'(data), 64'(rsData));
        check("wb stored rt", 64'(data), 64'(rtData));
    endtask

    task automatic testNopAndFlags();
        logic [15:0] nz;
        flushPipe();
        @(posedge clk);
        instr     <= {5'b00110, 11'($random(seed))};
        nopInsert <= 1'b1;
        @(negedge clk);
        check("nop ctrl", 64'(modelCtrl(5'b00001)), 64'(ctrl));
        check("nop branchKill", 64'(0), 64'(branchKill));
        check("nop nHalt", 64'(1), 64'(ctrl.nHalt));
        @(posedge clk);
        nopInsert <= 1'b0;
        instr     <= {5'b00100, 11'($random(seed))};
        @(negedge clk);
        check("nop regWrt", 64'(0), 64'(stage1.regWrt));
        check("J branchKill", 64'(1), 64'(branchKill));
        @(posedge clk);
        instr <= {5'b01100, 11'($random(seed))};
        @(negedge clk);
        check("BEQZ branchKill", 64'(1), 64'(branchKill));
        @(posedge clk);
        instr <= {5'b01000, 11'($random(seed))};
        @(negedge clk);
        check("ADDI branchKill", 64'(0), 64'(branchKill));
        for (int k = 0; k < 4; k++) begin
            nz = 16'($random(seed)) | 16'h0001;
            @(posedge clk);
            instr     <= k[1] ? nz : 16'h0000;
            instrNext <= k[0] ? nz : 16'h0000;
            @(negedge clk);
            check("valid", 64'(k[1] || !k[0]), 64'(valid));
        end
    endtask

    initial begin
        seed      = 64352;
        rstN      = 1'b0;
        instr     = ADDI_R7_WORD;
        instrNext = NOP_WORD;
        wbData    = '0;
        nopInsert = 1'b0;
        releaseReset();
        testReset();
        testControl();
        testImmediates();
        testWriteBack();
        testNopAndFlags();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- verilog/decode.sv
// Decode stage top: NOP forcing, destination select, immediates, register file and tag pipe
`include "decode_settings.svh"

module decode (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic [`DATA_WIDTH-1:0] instrNext,
    input  logic [`DATA_WIDTH-1:0] wbData,
    input  logic                   nopInsert,
    output decodePkg::ctrl_t       ctrl,
    output decodePkg::aluCtrl_t    alu,
    output decodePkg::immSet_t     imm,
    output logic [`DATA_WIDTH-1:0] rsData,
    output logic [`DATA_WIDTH-1:0] rtData,
    output decodePkg::wbTag_t      stage1,
    output decodePkg::wbTag_t      stage2,
    output decodePkg::wbTag_t      wbTag,
    output logic                   valid,
    output logic                   branchKill
);

    import decodePkg::*;

    logic [`DATA_WIDTH-1:0] ctrlInstr;
    aluOp_t                 aluOp;
    logic                   regWrt;
    dstSel_t                dstSel;
    logic                   zeroExt;
    logic [`REG_SEL_W-1:0]  rdSel;
    wbTag_t                 newTag;

    // Hazard unit bubble makes control see a NOP while operands still read normally
    assign ctrlInstr = nopInsert ? {OP_NOP, {(`DATA_WIDTH-`OPCODE_W){1'b0}}} : instr;

    instrControl uCtrl (
        .instr   (ctrlInstr),
        .ctrl    (ctrl),
        .aluOp   (aluOp),
        .regWrt  (regWrt),
        .dstSel  (dstSel),
        .zeroExt (zeroExt)
    );

    aluControl uAluCtrl (
        .aluOp (aluOp),
        .funct (instr[1:0]),
        .alu   (alu)
    );

    always_comb begin
        case (dstSel)
            FIELD_RT: rdSel = instr[7:5];
            FIELD_RS: rdSel = instr[10:8];
            FIELD_RD: rdSel = instr[4:2];
            default:  rdSel = {`REG_SEL_W{1'b1}};
        endcase
    end

    assign newTag = '{regWrt: regWrt, rd: rdSel};

    wbTagPipe uTagPipe (
        .clk    (clk),
        .rstN   (rstN),
        .newTag (newTag),
        .stage1 (stage1),
        .stage2 (stage2),
        .wbTag  (wbTag)
    );

    regFileBypass uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsSel  (instr[10:8]),
        .rtSel  (instr[7:5]),
        .wbTag  (wbTag),
        .wbData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    // Immediate forms; zeroExt only affects imm5 and imm8
    always_comb begin
        imm.sImm8  = {{(`DATA_WIDTH-8){instr[7]}}, instr[7:0]};
        imm.sImm11 = {{(`DATA_WIDTH-11){instr[10]}}, instr[10:0]};
        if (zeroExt) begin
            imm.imm5 = {{(`DATA_WIDTH-5){1'b0}}, instr[4:0]};
            imm.imm8 = {{(`DATA_WIDTH-8){1'b0}}, instr[7:0]};
        end else begin
            imm.imm5 = {{(`DATA_WIDTH-5){instr[4]}}, instr[4:0]};
            imm.imm8 = imm.sImm8;
        end
    end

    // All-zero word is only a real instruction when fetch also has nothing
    assign valid = (|instr) | ~(|instrNext);

    assign branchKill = ctrl.branchKind[BR_JUMP] | ctrl.branchKind[BR_ZERO];

endmodule

//--- verilog/wbTagPipe.sv
// Three-stage shift of write-back tags with the first two stages exposed
module wbTagPipe (
    input  logic              clk,
    input  logic              rstN,
    input  decodePkg::wbTag_t newTag,
    output decodePkg::wbTag_t stage1,
    output decodePkg::wbTag_t stage2,
    output decodePkg::wbTag_t wbTag
);

    import decodePkg::*;

    // Tags follow the instruction through execute and memory
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage1 <= '0;
            stage2 <= '0;
            wbTag  <= '0;
        end else begin
            stage1 <= newTag;
            stage2 <= stage1;
            wbTag  <= stage2;
        end
    end

    // No stray write may leave the pipe right after reset
    cleanAfterReset: assert property (
        @(posedge clk)
        $rose(rstN) |-> !wbTag.regWrt
    ) else $error("write-back tag active on first clock after reset");

endmodule

//--- verilog/regFileBypass.sv
// Eight-entry register file: two read ports, one write port, write-to-read bypass
`include "decode_settings.svh"

module regFileBypass (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`REG_SEL_W-1:0]  rsSel,
    input  logic [`REG_SEL_W-1:0]  rtSel,
    input  decodePkg::wbTag_t      wbTag,
    input  logic [`DATA_WIDTH-1:0] wbData,
    output logic [`DATA_WIDTH-1:0] rsData,
    output logic [`DATA_WIDTH-1:0] rtData
);

    import decodePkg::*;

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   rsHit;
    logic                   rtHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbTag.regWrt) begin
            regs[wbTag.rd] <= wbData;
        end
    end

    // Same-cycle write forwards straight to the read port
    assign rsHit = wbTag.regWrt && (wbTag.rd == rsSel);
    assign rtHit = wbTag.regWrt && (wbTag.rd == rtSel);

    assign rsData = rsHit ? wbData : regs[rsSel];
    assign rtData = rtHit ? wbData : regs[rtSel];

    // A write arriving from the tag pipe must name a real register
    wrtTargetKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        wbTag.regWrt |-> !$isunknown(wbTag.rd)
    ) else $error("register write with unknown destination");

endmodule

//--- verilog/aluControl.sv
// ALU control: operation class and R-type funct to operation code, inversions and carry-in
module aluControl (
    input  decodePkg::aluOp_t   aluOp,
    input  logic [1:0]          funct,
    output decodePkg::aluCtrl_t alu
);

    import decodePkg::*;

    always_comb begin
        alu = '0;

        case (aluOp)
            ALU_PASS: alu.oper = OPER_PASSB;
            ALU_AND:  alu.oper = OPER_AND;
            ALU_ANDN: begin
                // AND with the inverted immediate
                alu.oper = OPER_AND;
                alu.invB = 1'b1;
            end
            ALU_RTYPE: begin
                case (funct)
                    2'b00: alu.oper = OPER_ADD;
                    2'b01: begin
                        // Subtract as A + ~B + 1
                        alu.oper = OPER_ADD;
                        alu.invB = 1'b1;
                        alu.cin  = 1'b1;
                    end
                    2'b10: alu.oper = OPER_AND;
                    default: alu.oper = OPER_XOR;
                endcase
            end
            default: alu.oper = OPER_ADD;
        endcase
    end

endmodule

//--- verilog/instrControl.sv
// Main control decoder: opcode to control struct, ALU class, write-back tag fields, extend mode
`include "decode_settings.svh"

module instrControl (
    input  logic [`DATA_WIDTH-1:0] instr,
    output decodePkg::ctrl_t       ctrl,
    output decodePkg::aluOp_t      aluOp,
    output logic                   regWrt,
    output decodePkg::dstSel_t     dstSel,
    output logic                   zeroExt
);

    import decodePkg::*;

    opcode_t opcode;

    assign opcode = opcode_t'(instr[`DATA_WIDTH-1 -: `OPCODE_W]);

    always_comb begin
        // Idle defaults; every row only sets what it needs
        ctrl       = '0;
        ctrl.nHalt = 1'b1;
        aluOp      = ALU_ADD;
        regWrt     = 1'b0;
        dstSel     = FIELD_RT;
        zeroExt    = 1'b0;

        case (opcode)
            OP_ADDI: begin
                regWrt      = 1'b1;
                dstSel      = FIELD_RT;
                aluOp       = ALU_ADD;
                ctrl.bSrc   = B_SRC_IMM5;
                ctrl.immSrc = 1'b1;
            end
            OP_ANDNI: begin
                regWrt    = 1'b1;
                dstSel    = FIELD_RT;
                aluOp     = ALU_ANDN;
                ctrl.bSrc = B_SRC_IMM5;
                zeroExt   = 1'b1;
            end
            OP_LD: begin
                regWrt       = 1'b1;
                dstSel       = FIELD_RT;
                aluOp        = ALU_ADD;
                ctrl.bSrc    = B_SRC_IMM5;
                ctrl.memRead = 1'b1;
                ctrl.regSrc  = REG_SRC_MEM;
            end
            OP_ST: begin
                aluOp       = ALU_ADD;
                ctrl.bSrc   = B_SRC_IMM5;
                ctrl.memWrt = 1'b1;
            end
            OP_LBI: begin
                regWrt      = 1'b1;
                dstSel      = FIELD_RS;
                aluOp       = ALU_PASS;
                ctrl.bSrc   = B_SRC_IMM8;
                ctrl.regSrc = REG_SRC_IMM;
            end
            OP_RTYPE: begin
                regWrt = 1'b1;
                dstSel = FIELD_RD;
                aluOp  = ALU_RTYPE;
            end
            OP_BEQZ: begin
                ctrl.bSrc                = B_SRC_IMM8;
                ctrl.branchKind[BR_ZERO] = 1'b1;
            end
            OP_J: begin
                ctrl.bSrc                = B_SRC_SIMM11;
                ctrl.branchKind[BR_JUMP] = 1'b1;
                ctrl.aluJmp              = 1'b1;
            end
            OP_JAL: begin
                // Jump that also links PC+2 into r7
                regWrt                   = 1'b1;
                dstSel                   = LINK;
                ctrl.bSrc                = B_SRC_SIMM11;
                ctrl.branchKind[BR_JUMP] = 1'b1;
                ctrl.aluJmp              = 1'b1;
                ctrl.regSrc              = REG_SRC_PC2;
            end
            OP_HALT: begin
                ctrl.nHalt = 1'b0;
            end
            default: begin
                // OP_NOP and every undefined opcode
                ctrl.nop = 1'b1;
            end
        endcase
    end

endmodule

//--- verilog/decodePkg.sv
// Decode package: opcode, ALU class and destination enums, control and tag structs
`include "decode_settings.svh"

package decodePkg;

    // Opcodes in instr[15:11]; anything else decodes as NOP
    typedef enum logic [`OPCODE_W-1:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_LBI   = 5'b11000,
        OP_RTYPE = 5'b11011
    } opcode_t;

    // ALU operation class; ALU_ADD is zero so idle rows give an all-zero ALU word
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_PASS  = 3'd1,
        ALU_AND   = 3'd2,
        ALU_ANDN  = 3'd3,
        ALU_RTYPE = 3'd4
    } aluOp_t;

    // Which instruction field names the destination
    typedef enum logic [1:0] {
        FIELD_RT = 2'd0,
        FIELD_RS = 2'd1,
        FIELD_RD = 2'd2,
        LINK     = 2'd3
    } dstSel_t;

    // ALU operation codes
    localparam logic [3:0] OPER_ADD   = 4'd0;
    localparam logic [3:0] OPER_AND   = 4'd1;
    localparam logic [3:0] OPER_XOR   = 4'd2;
    localparam logic [3:0] OPER_PASSB = 4'd3;

    // Write-back source and B-operand source encodings
    localparam logic [1:0] REG_SRC_MEM = 2'b01;
    localparam logic [1:0] REG_SRC_PC2 = 2'b10;
    localparam logic [1:0] REG_SRC_IMM = 2'b11;
    localparam logic [1:0] B_SRC_IMM5   = 2'b01;
    localparam logic [1:0] B_SRC_IMM8   = 2'b10;
    localparam logic [1:0] B_SRC_SIMM11 = 2'b11;

    // One-hot branch kind bit positions
    localparam int BR_JUMP = 3;
    localparam int BR_ZERO = 2;

    typedef struct packed {
        logic       memRead;
        logic       memWrt;
        logic       immSrc;
        logic       aluSign;
        logic       aluJmp;
        logic [1:0] regSrc;
        logic [1:0] bSrc;
        logic [3:0] branchKind;
        logic       nHalt;
        logic       nop;
    } ctrl_t;

    typedef struct packed {
        logic [3:0] oper;
        logic       invA;
        logic       invB;
        logic       cin;
    } aluCtrl_t;

    typedef struct packed {
        logic                  regWrt;
        logic [`REG_SEL_W-1:0] rd;
    } wbTag_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] imm5;
        logic [`DATA_WIDTH-1:0] imm8;
        logic [`DATA_WIDTH-1:0] sImm8;
        logic [`DATA_WIDTH-1:0] sImm11;
    } immSet_t;

endpackage

//--- include/decode_settings.svh
// Width macros for the decode stage: data word, register count, register select
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Data and instruction word width
`define DATA_WIDTH 16

// General registers in the register file
`define REG_COUNT 8

// Bits needed to select one register
`define REG_SEL_W 3

// Opcode field sits in the top five bits of the instruction
`define OPCODE_W 5

`endif
